// File: common/dma_cfg.svh
// Sizing defines for the DMA block mover, included by the package and by modules that size storage
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Request FIFO depth per channel
// The client also starts with this many credits per channel
`define DMA_REQ_DEPTH 4

// Response FIFO depth, also the sink's credit count after reset
`define DMA_RSP_DEPTH 4

// Word memory size in 32-bit words, a power of two
`define DMA_MEM_WORDS 256

// Beats per 16-byte block on the 32-bit bus
`define DMA_BEATS 4

// Byte address width on the internal bus
`define DMA_ADDR_W 16

`endif

// File: common/dma_pkg.sv
// Shared opcode, state and transfer types for the DMA block mover, imported by every RTL module
`include "dma_cfg.svh"

package dma_pkg;

   // Client opcode
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } dma_op_e;

   // Bus controller FSM states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_REQ,
      ST_BEAT,
      ST_WAIT,
      ST_DONE
   } ctrl_state_e;

   // Block request from the client
   // addr is a byte address aligned to the block
   typedef struct packed {
      dma_op_e                      op;
      logic [`DMA_ADDR_W-1:0]       addr;
      logic [`DMA_BEATS*32-1:0]     wdata;
   } dma_req_t;

   // Completion sent to the sink
   // rdata stays zero for writes
   typedef struct packed {
      logic                         chan;
      dma_op_e                      op;
      logic [`DMA_ADDR_W-1:0]       addr;
      logic [`DMA_BEATS*32-1:0]     rdata;
   } dma_rsp_t;

   // One beat from bus master to memory
   typedef struct packed {
      logic                         valid;
      logic                         rw;
      logic [`DMA_ADDR_W-1:0]       addr;
      logic [31:0]                  wdata;
   } bus_req_t;

   // Memory reply to a beat
   typedef struct packed {
      logic                         ack;
      logic [31:0]                  rdata;
   } bus_rsp_t;

endpackage

// File: bus_ctrl/dma_bus_controller.sv
// Per-channel bus master that takes one block request, moves four beats and reports completion
`include "dma_cfg.svh"

module dma_bus_controller (
   input  logic                bus_clk,
   input  logic                rst_n,
   input  logic                chan,
   // Request FIFO side
   input  logic                q_valid,
   input  dma_pkg::dma_req_t   q_req,
   output logic                q_ready,
   // Arbiter handshake
   output logic                br,
   input  logic                bg,
   // Bus beats to and from the memory
   output dma_pkg::bus_req_t   bus_out,
   input  dma_pkg::bus_rsp_t   bus_in,
   // Completion towards the response queue
   output logic                done_valid,
   output dma_pkg::dma_rsp_t   done_rsp,
   input  logic                done_ready
);
   import dma_pkg::*;

   localparam int BEAT_W = $clog2(`DMA_BEATS);

   ctrl_state_e                 state;
   ctrl_state_e                 state_next;
   dma_req_t                    cur_req;
   logic [BEAT_W-1:0]           beat;
   logic [`DMA_BEATS*32-1:0]    rbuf;
   logic                        last_beat;
   logic                        beat_acked;

   assign last_beat  = (beat == BEAT_W'(`DMA_BEATS - 1));
   // Ack only counts while a beat is in flight
   assign beat_acked = (state == ST_WAIT) && bus_in.ack;

   always_comb begin
      state_next = state;
      unique case (state)
         ST_IDLE: begin
            if (q_valid) begin
               state_next = ST_REQ;
            end
         end
         // Hold br until the registered grant shows up
         ST_REQ: begin
            if (bg) begin
               state_next = ST_BEAT;
            end
         end
         ST_BEAT: begin
            state_next = ST_WAIT;
         end
         ST_WAIT: begin
            if (bus_in.ack) begin
               state_next = last_beat ? ST_DONE : ST_BEAT;
            end
         end
         ST_DONE: begin
            if (done_ready) begin
               state_next = ST_IDLE;
            end
         end
         default: begin
            state_next = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         beat  <= '0;
      end else begin
         state <= state_next;
         // Beat index counts up, the buffer slot follows it
         if (state == ST_IDLE) begin
            beat <= '0;
         end else if (beat_acked) begin
            beat <= beat + 1'b1;
         end
      end
   end

   // Request capture and read buffer
   always_ff @(posedge bus_clk) begin
      if (state == ST_IDLE && q_valid) begin
         cur_req <= q_req;
         // Cleared per request so write completions carry zero
         rbuf    <= '0;
      end else if (beat_acked && cur_req.op == OP_READ) begin
         rbuf[32*beat +: 32] <= bus_in.rdata;
      end
   end

   assign q_ready = (state == ST_IDLE);
   // Bus stays requested through the last ack
   assign br      = (state == ST_REQ) || (state == ST_BEAT) || (state == ST_WAIT);

   // Beat i goes to word i of the block
   assign bus_out.valid = (state == ST_BEAT) || (state == ST_WAIT);
   assign bus_out.rw    = (cur_req.op == OP_WRITE);
   assign bus_out.addr  = {cur_req.addr[`DMA_ADDR_W-1:BEAT_W+2], beat, 2'b00};
   assign bus_out.wdata = cur_req.wdata[32*beat +: 32];

   assign done_valid     = (state == ST_DONE);
   assign done_rsp.chan  = chan;
   assign done_rsp.op    = cur_req.op;
   assign done_rsp.addr  = cur_req.addr;
   assign done_rsp.rdata = rbuf;

   // Only the bus owner may drive a beat
   a_valid_needs_grant: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      bus_out.valid |-> bg
   );

endmodule

// File: src/dma_request_queue.sv
// Per-channel request FIFO between the client and a bus controller, returning a credit per pop
`include "dma_cfg.svh"

module dma_request_queue (
   input  logic                bus_clk,
   input  logic                rst_n,
   input  logic                req_valid,
   input  dma_pkg::dma_req_t   req,
   output logic                req_credit,
   output logic                q_valid,
   output dma_pkg::dma_req_t   q_req,
   input  logic                q_ready
);
   import dma_pkg::*;

   // Depth must be a power of two so the pointers wrap on their own
   localparam int DEPTH = `DMA_REQ_DEPTH;
   localparam int PW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   dma_req_t         fifo_mem [DEPTH];
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             pop;

   assign q_valid = (count != '0);
   assign q_req   = fifo_mem[rd_ptr];
   assign pop     = q_valid && q_ready;

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         req_credit <= 1'b0;
      end else begin
         if (req_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count      <= count + CW'(req_valid) - CW'(pop);
         // One credit back per freed slot
         req_credit <= pop;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (req_valid) begin
         fifo_mem[wr_ptr] <= req;
      end
   end

   // Client pushed without a credit
   a_no_push_when_full: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      req_valid |-> (count != CW'(DEPTH))
   );

endmodule

// File: src/bus_arbiter.sv
// Round-robin arbiter for the two bus controllers, holding the grant while the owner keeps br high
module bus_arbiter (
   input  logic        bus_clk,
   input  logic        rst_n,
   input  logic [1:0]  br,
   output logic [1:0]  bg
);

   logic   last_owner;
   logic   owner_busy;
   logic   pick;
   logic   pick_valid;

   // Current owner still wants the bus
   assign owner_busy = |(bg & br);

   // Other channel first, then the last owner again
   always_comb begin
      pick       = last_owner;
      pick_valid = 1'b0;
      if (br[!last_owner]) begin
         pick       = !last_owner;
         pick_valid = 1'b1;
      end else if (br[last_owner]) begin
         pick       = last_owner;
         pick_valid = 1'b1;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         bg         <= 2'b00;
         last_owner <= 1'b0;
      end else if (!owner_busy) begin
         if (pick_valid) begin
            bg         <= pick ? 2'b10 : 2'b01;
            last_owner <= pick;
         end else begin
            bg <= 2'b00;
         end
      end
   end

   a_grant_onehot: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      $onehot0(bg)
   );

endmodule

// File: src/bus_memory.sv
// Word memory slave on the internal bus, acking each beat one cycle after it appears
`include "dma_cfg.svh"

module bus_memory (
   input  logic                bus_clk,
   input  logic                rst_n,
   input  dma_pkg::bus_req_t   bus_in,
   output dma_pkg::bus_rsp_t   bus_out
);
   import dma_pkg::*;

   localparam int MEM_AW = $clog2(`DMA_MEM_WORDS);

   logic [31:0]         mem [`DMA_MEM_WORDS];
   logic [MEM_AW-1:0]   idx;
   logic                accept;
   logic                ack_q;
   logic [31:0]         rdata_q;

   // Byte address to word index
   assign idx = bus_in.addr[MEM_AW+1:2];

   // A held beat is taken once, the ack cycle does not count again
   assign accept = bus_in.valid && !ack_q;

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   // Old word is returned, the write lands in the same cycle
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         rdata_q <= mem[idx];
         if (bus_in.rw) begin
            mem[idx] <= bus_in.wdata;
         end
      end
   end

   assign bus_out.ack   = ack_q;
   assign bus_out.rdata = rdata_q;

   // Master keeps the beat up until it sees the ack
   a_beat_held: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      accept |=> bus_in.valid && $stable(bus_in.addr)
   );

endmodule

// File: src/dma_response_queue.sv
// Response FIFO merging both channels' completions and sending them to the sink against credits
`include "dma_cfg.svh"

module dma_response_queue (
   input  logic                      bus_clk,
   input  logic                      rst_n,
   input  logic [1:0]                done_valid,
   input  dma_pkg::dma_rsp_t [1:0]   done_rsp,
   output logic [1:0]                done_ready,
   output logic                      rsp_valid,
   output dma_pkg::dma_rsp_t         rsp,
   input  logic                      rsp_credit
);
   import dma_pkg::*;

   localparam int DEPTH = `DMA_RSP_DEPTH;
   localparam int PW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   dma_rsp_t         fifo_mem [DEPTH];
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic [CW-1:0]    credits;
   logic             push;
   logic             full;

   assign full = (count == CW'(DEPTH));
   // Channel 0 wins, one completion per cycle
   assign done_ready[0] = !full;
   assign done_ready[1] = !full && !done_valid[0];
   assign push          = |(done_valid & done_ready);

   // Send straight from the head while the sink has room
   assign rsp_valid = (count != '0) && (credits != '0);
   assign rsp       = fifo_mem[rd_ptr];

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CW'(DEPTH);
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rsp_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count + CW'(push) - CW'(rsp_valid);
         credits <= credits + CW'(rsp_credit) - CW'(rsp_valid);
      end
   end

   always_ff @(posedge bus_clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= done_valid[0] ? done_rsp[0] : done_rsp[1];
      end
   end

   a_send_needs_credit: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      rsp_valid |-> (credits != '0)
   );

   // Sink returned a credit it never received
   a_credit_overflow: assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      (credits == CW'(DEPTH)) |-> !rsp_credit
   );

endmodule

// File: src/dma_subsystem.sv
// Top level of the two-channel DMA block mover, joining queues, controllers, arbiter and memory
module dma_subsystem (
   input  logic                      bus_clk,
   input  logic                      rst_n,
   // Client side, one lane per channel
   input  logic [1:0]                req_valid,
   input  dma_pkg::dma_req_t [1:0]   req,
   output logic [1:0]                req_credit,
   // Sink side
   output logic                      rsp_valid,
   output dma_pkg::dma_rsp_t         rsp,
   input  logic                      rsp_credit
);
   import dma_pkg::*;

   logic [1:0]          q_valid;
   logic [1:0]          q_ready;
   dma_req_t [1:0]      q_req;
   logic [1:0]          br;
   logic [1:0]          bg;
   bus_req_t [1:0]      ctrl_bus_req;
   bus_rsp_t [1:0]      ctrl_bus_rsp;
   bus_req_t            mem_bus_req;
   bus_rsp_t            mem_bus_rsp;
   logic [1:0]          done_valid;
   logic [1:0]          done_ready;
   dma_rsp_t [1:0]      done_rsp;

   for (genvar i = 0; i < 2; i++) begin : g_chan
      dma_request_queue u_req_queue (
         .bus_clk    (bus_clk),
         .rst_n      (rst_n),
         .req_valid  (req_valid[i]),
         .req        (req[i]),
         .req_credit (req_credit[i]),
         .q_valid    (q_valid[i]),
         .q_req      (q_req[i]),
         .q_ready    (q_ready[i])
      );

      dma_bus_controller u_bus_ctrl (
         .bus_clk    (bus_clk),
         .rst_n      (rst_n),
         .chan       (1'(i)),
         .q_valid    (q_valid[i]),
         .q_req      (q_req[i]),
         .q_ready    (q_ready[i]),
         .br         (br[i]),
         .bg         (bg[i]),
         .bus_out    (ctrl_bus_req[i]),
         .bus_in     (ctrl_bus_rsp[i]),
         .done_valid (done_valid[i]),
         .done_rsp   (done_rsp[i]),
         .done_ready (done_ready[i])
      );

      // Ack reaches only the owner, read data is shared
      assign ctrl_bus_rsp[i].ack   = mem_bus_rsp.ack && bg[i];
      assign ctrl_bus_rsp[i].rdata = mem_bus_rsp.rdata;
   end

   bus_arbiter u_arbiter (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .br      (br),
      .bg      (bg)
   );

   // Granted master drives the memory, idle bus otherwise
   assign mem_bus_req = bg[1] ? ctrl_bus_req[1] : (bg[0] ? ctrl_bus_req[0] : '0);

   bus_memory u_memory (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .bus_in  (mem_bus_req),
      .bus_out (mem_bus_rsp)
   );

   dma_response_queue u_rsp_queue (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .done_valid (done_valid),
      .done_rsp   (done_rsp),
      .done_ready (done_ready),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit)
   );

endmodule

// File: testbench/tb_dma_subsystem.sv
// Testbench for the DMA subsystem, runs the request batches listed in testbench/dma_testdata.txt
`include "dma_cfg.svh"

module tb_dma_subsystem;
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   localparam int MAX_TESTS  = 64;
   localparam int RST_CYCLES = 5;

   logic                bus_clk;
   logic                rst_n;
   logic [1:0]          req_valid;
   dma_req_t [1:0]      req;
   logic [1:0]          req_credit;
   logic                rsp_valid;
   dma_rsp_t            rsp;
   logic                rsp_credit;

   // Test table loaded from the data file
   int                  n_tests;
   int                  t_batch [MAX_TESTS];
   bit                  t_hold [MAX_TESTS];
   dma_op_e             t_op [MAX_TESTS];
   int                  t_chan [MAX_TESTS];
   logic [15:0]         t_addr [MAX_TESTS];
   logic [127:0]        t_wdata [MAX_TESTS];
   logic [127:0]        t_exp [MAX_TESTS];
   dma_rsp_t            exp_rsp [MAX_TESTS];
   // Block contents as the data file writes them, 64 blocks of 16 bytes
   logic [127:0]        model_mem [64];
   bit                  model_ok [64];

   // Per-channel order of outstanding tests
   int                  order0 [$];
   int                  order1 [$];
   int                  client_credits [2];
   int                  credit_pulses [2];
   int                  reqs_sent [2];
   int                  outstanding;
   int                  pending;
   int                  rx_count;
   bit                  hold_credits;
   bit                  first_req_sent;
   bit                  loaded;
   int                  errors;
   int                  tests_passed;

   dma_subsystem uut (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit)
   );

   initial begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;
   end

   task automatic check_rsp(input string name, input dma_rsp_t got, input dma_rsp_t exp,
                            output bit ok);
      ok = (got === exp);
      if (!ok) begin
         $display("error %s (got/exp): chan %h/%h op %h/%h addr %h/%h rdata %h/%h",
                  name, got.chan, exp.chan, got.op, exp.op,
                  got.addr, exp.addr, got.rdata, exp.rdata);
         errors++;
      end
   endtask

   task automatic check_credit(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Reads the test table, cross-checks read data against the block model
   task automatic load_tests();
      int           fd;
      int           code;
      int           b;
      int           h;
      int           o;
      int           c;
      logic [15:0]  a;
      logic [127:0] wd;
      logic [127:0] ex;
      string        line;
      fd = $fopen("testbench/dma_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open test data file testbench/dma_testdata.txt");
         errors++;
      end else begin
         while (!$feof(fd) && n_tests < MAX_TESTS) begin
            code = $fgets(line, fd);
            // Comment and blank lines give fewer than 7 fields
            if (code != 0 &&
                $sscanf(line, "%d %d %d %d %h %h %h", b, h, o, c, a, wd, ex) == 7) begin
               t_batch[n_tests] = b;
               t_hold[n_tests]  = (h != 0);
               t_op[n_tests]    = (o != 0) ? OP_WRITE : OP_READ;
               t_chan[n_tests]  = c;
               t_addr[n_tests]  = a;
               t_wdata[n_tests] = wd;
               // Write completions always carry zero
               t_exp[n_tests]   = (o != 0) ? '0 : ex;
               if (o != 0) begin
                  model_mem[a[9:4]] = wd;
                  model_ok[a[9:4]]  = 1'b1;
               end else if (!model_ok[a[9:4]] || model_mem[a[9:4]] !== ex) begin
                  $display("test data line %0d reads block %h with data the model disagrees with",
                           n_tests, a);
                  errors++;
               end
               n_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   function automatic int next_line(input int from, input int last, input int ch);
      int i;
      i = from;
      while (i <= last && t_chan[i] != ch) begin
         i++;
      end
      return i;
   endfunction

   task automatic issue(input int ch, input int i);
      req_valid[ch] = 1'b1;
      req[ch]       = '{op: t_op[i], addr: t_addr[i], wdata: t_wdata[i]};
      exp_rsp[i]    = '{chan: 1'(ch), op: t_op[i], addr: t_addr[i], rdata: t_exp[i]};
      if (ch == 0) begin
         order0.push_back(i);
      end else begin
         order1.push_back(i);
      end
      client_credits[ch]--;
      reqs_sent[ch]++;
      outstanding++;
      first_req_sent = 1'b1;
   endtask

   // Both channels issue in parallel, each only while it holds a credit
   task automatic run_batch(input int first, input int last);
      int p [2];
      hold_credits = t_hold[first];
      rx_count     = 0;
      p[0] = next_line(first, last, 0);
      p[1] = next_line(first, last, 1);
      while (p[0] <= last || p[1] <= last) begin
         @(posedge bus_clk);
         #2;
         req_valid = '0;
         for (int ch = 0; ch < 2; ch++) begin
            if (p[ch] <= last && client_credits[ch] > 0) begin
               issue(ch, p[ch]);
               p[ch] = next_line(p[ch] + 1, last, ch);
            end
         end
      end
      @(posedge bus_clk);
      #2;
      req_valid = '0;
      if (hold_credits) begin
         // Sink stays silent, only the initial credits may be spent
         wait (rx_count >= `DMA_RSP_DEPTH);
         repeat (50) @(posedge bus_clk);
         check_credit("responses while credits held", rx_count, `DMA_RSP_DEPTH);
         hold_credits = 1'b0;
      end
      wait (outstanding == 0);
      wait (pending == 0);
   endtask

   task automatic check_response(input dma_rsp_t got);
      int idx;
      bit ok;
      if ((got.chan == 1'b0 && order0.size() == 0) ||
          (got.chan == 1'b1 && order1.size() == 0)) begin
         $display("response on channel %0d arrived with no request outstanding", got.chan);
         errors++;
      end else begin
         idx = (got.chan == 1'b0) ? order0.pop_front() : order1.pop_front();
         check_rsp("rsp", got, exp_rsp[idx], ok);
         $display("test %0d %s ch%0d addr %h: %s", idx, exp_rsp[idx].op.name(),
                  exp_rsp[idx].chan, exp_rsp[idx].addr, ok ? "ok" : "mismatch");
         if (ok) begin
            tests_passed++;
         end
         outstanding--;
      end
   endtask

   // Output monitor, mid-cycle where DUT outputs are settled
   always @(negedge bus_clk) begin
      if (rst_n) begin
         if (!first_req_sent && (rsp_valid || req_credit != 2'b00)) begin
            $display("rsp_valid or req_credit went high before the first request");
            errors++;
         end
         for (int ch = 0; ch < 2; ch++) begin
            if (req_credit[ch]) begin
               credit_pulses[ch]++;
               client_credits[ch]++;
            end
         end
         if (rsp_valid) begin
            pending++;
            rx_count++;
            if (pending > `DMA_RSP_DEPTH) begin
               $display("sink received more responses than credits it had granted");
               errors++;
            end
            check_response(rsp);
         end
      end
   end

   // Sink returns one credit per response after a random gap
   initial begin : credit_return
      int gap;
      gap = 0;
      forever begin
         @(posedge bus_clk);
         #2;
         rsp_credit = 1'b0;
         if (pending > 0 && !hold_credits) begin
            if (gap == 0) begin
               rsp_credit = 1'b1;
               pending--;
               gap = $urandom_range(3, 0);
            end else begin
               gap--;
            end
         end
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (n_tests * 200 + RST_CYCLES + 20) @(posedge bus_clk);
      $display("timeout with %0d responses still outstanding", outstanding);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : main
      int first;
      int last;
      req_valid  = '0;
      req        = '0;
      rsp_credit = 1'b0;
      rst_n      = 1'b0;
      for (int ch = 0; ch < 2; ch++) begin
         client_credits[ch] = `DMA_REQ_DEPTH;
      end
      void'($urandom(32'h5d34));
      load_tests();
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge bus_clk);
      #2;
      rst_n = 1'b1;
      // Quiet period, monitor flags any early output
      repeat (10) @(posedge bus_clk);
      first = 0;
      while (first < n_tests) begin
         last = first;
         while (last + 1 < n_tests && t_batch[last + 1] == t_batch[first]) begin
            last++;
         end
         run_batch(first, last);
         first = last + 1;
      end
      for (int ch = 0; ch < 2; ch++) begin
         check_credit($sformatf("req_credit pulses ch%0d", ch), credit_pulses[ch],
                      reqs_sent[ch]);
         check_credit($sformatf("client credits ch%0d", ch), client_credits[ch], `DMA_REQ_DEPTH);
      end
      $display("%0d of %0d tests passed, %0d errors", tests_passed, n_tests, errors);
      if (errors == 0 && tests_passed == n_tests && n_tests > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+common
common/dma_pkg.sv
bus_ctrl/dma_bus_controller.sv
src/dma_request_queue.sv
src/bus_arbiter.sv
src/bus_memory.sv
src/dma_response_queue.sv
src/dma_subsystem.sv
testbench/tb_dma_subsystem.sv

// File: testbench/dma_testdata.txt
# batch(dec) hold(dec) op(dec 0 read 1 write) chan(dec) addr(hex) wdata(hex) exp_rdata(hex)
# Lines of one batch issue together, hold 1 withholds sink credits for that batch
1 0 1 0 0000 00112233445566778899aabbccddeeff 0
1 0 0 0 0000 0 00112233445566778899aabbccddeeff
2 0 1 0 0040 deadbeef0badf00dcafef00d12345678 0
3 0 0 1 0040 0 deadbeef0badf00dcafef00d12345678
4 0 1 0 0100 11111111222222223333333344444444 0
4 0 1 1 0200 a5a5a5a55a5a5a5af0f0f0f00f0f0f0f 0
4 0 0 0 0100 0 11111111222222223333333344444444
4 0 0 1 0200 0 a5a5a5a55a5a5a5af0f0f0f00f0f0f0f
5 1 1 0 0300 c0de0300c0de0301c0de0302c0de0303 0
5 1 1 1 0380 b0b00380b0b00381b0b00382b0b00383 0
5 1 1 0 0310 c0de0310c0de0311c0de0312c0de0313 0
5 1 1 1 0390 b0b00390b0b00391b0b00392b0b00393 0
5 1 1 0 0320 c0de0320c0de0321c0de0322c0de0323 0
5 1 0 1 0380 0 b0b00380b0b00381b0b00382b0b00383
5 1 0 0 0300 0 c0de0300c0de0301c0de0302c0de0303
5 1 0 1 0040 0 deadbeef0badf00dcafef00d12345678
5 1 0 0 0000 0 00112233445566778899aabbccddeeff
5 1 0 1 0200 0 a5a5a5a55a5a5a5af0f0f0f00f0f0f0f
6 0 0 1 0310 0 c0de0310c0de0311c0de0312c0de0313
6 0 0 0 0390 0 b0b00390b0b00391b0b00392b0b00393
6 0 1 0 0000 fedcba98765432100123456789abcdef 0
6 0 0 0 0000 0 fedcba98765432100123456789abcdef
